// ==== design/mipsCore_config.svh ====
`ifndef MIPS_CORE_CONFIG_SVH
`define MIPS_CORE_CONFIG_SVH

// Datapath and address width
`define MIPS_WORD_BITS   32

// Architectural registers
`define MIPS_NUM_REGS    32

// First fetch address after reset
`define MIPS_RESET_PC    32'h0000_0000

// Fetch to decode queue entries
`define MIPS_QUEUE_DEPTH 8

`endif

// ==== design/mipsPkg.sv ====
`default_nettype none

`include "mipsCore_config.svh"

package mipsPkg;

    typedef logic [`MIPS_WORD_BITS-1:0]          wordT;
    typedef logic [`MIPS_WORD_BITS-1:0]          addrT;
    typedef logic [$clog2(`MIPS_NUM_REGS)-1:0]   regIdxT;
    typedef logic [3:0]                          aluOpT;

    // ALU function select
    localparam aluOpT aluAdd = 4'd0;
    localparam aluOpT aluSub = 4'd1;
    localparam aluOpT aluAnd = 4'd2;
    localparam aluOpT aluOr  = 4'd3;
    localparam aluOpT aluXor = 4'd4;
    localparam aluOpT aluSlt = 4'd5;
    localparam aluOpT aluSll = 4'd6;
    localparam aluOpT aluSrl = 4'd7;
    localparam aluOpT aluLui = 4'd8;

    // Data side sequencer
    typedef enum logic [1:0] {
        idle,
        busy,
        writeback
    } memStateT;

endpackage

`default_nettype wire

// ==== design/stageBuses.sv ====
`timescale 1ns/1ns
`default_nettype none

// ----------------------------------------------------------------------
// Decode to execute
// ----------------------------------------------------------------------
interface issueBus;
    import mipsPkg::*;

    logic   valid;
    logic   ready;
    aluOpT  aluOp;
    regIdxT destReg;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    wordT   opA;
    wordT   opB;
    wordT   storeData;

    modport sender (output valid, aluOp, destReg, regWrite, memRead, memWrite,
                    output opA, opB, storeData, input ready);
    modport receiver (input valid, aluOp, destReg, regWrite, memRead, memWrite,
                      input opA, opB, storeData, output ready);
endinterface

// ----------------------------------------------------------------------
// Execute to memory
// ----------------------------------------------------------------------
interface memBus;
    import mipsPkg::*;

    logic   valid;
    logic   ready;
    wordT   result;
    regIdxT destReg;
    logic   regWrite;
    logic   memRead;
    logic   memWrite;
    wordT   storeData;

    modport sender (output valid, result, destReg, regWrite, memRead, memWrite,
                    output storeData, input ready);
    modport receiver (input valid, result, destReg, regWrite, memRead, memWrite,
                      input storeData, output ready);
endinterface

`default_nettype wire

// ==== design/fetchUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mipsCore_config.svh"

module fetchUnit (
    input  logic          CLK,
    input  logic          arstN,
    input  logic          redirect,
    input  mipsPkg::addrT target,
    input  logic          queueFull,
    input  mipsPkg::wordT instrData,
    output mipsPkg::addrT instrAddr,
    output logic          push,
    output mipsPkg::wordT pushWord,
    output mipsPkg::addrT pushPc
);
    import mipsPkg::*;

    addrT pc;

    // Instruction memory answers in the same cycle
    assign instrAddr = pc;
    assign pushWord  = instrData;
    assign pushPc    = pc;

    // The word fetched under a redirect is on the wrong path
    assign push = !queueFull && !redirect;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            pc <= `MIPS_RESET_PC;
        end else if (redirect) begin
            pc <= target;
        end else if (push) begin
            pc <= pc + addrT'(4);
        end
    end

endmodule

`default_nettype wire

// ==== design/instrQueue.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mipsCore_config.svh"

module instrQueue #(
    parameter int depth = `MIPS_QUEUE_DEPTH
) (
    input  logic          CLK,
    input  logic          arstN,
    input  logic          flush,
    input  logic          push,
    input  logic          pop,
    input  mipsPkg::wordT pushWord,
    input  mipsPkg::addrT pushPc,
    output logic          full,
    output logic          empty,
    output mipsPkg::wordT headWord,
    output mipsPkg::addrT headPc
);
    import mipsPkg::*;

    localparam int ptrBits   = (depth > 1) ? $clog2(depth) : 1;
    localparam int countBits = $clog2(depth + 1);

    wordT                 words [depth];
    addrT                 pcs   [depth];
    logic [ptrBits-1:0]   rdPtr;
    logic [ptrBits-1:0]   wrPtr;
    logic [countBits-1:0] count;
    logic                 doPush;
    logic                 doPop;

    // Wrap explicitly so that any depth works
    function automatic logic [ptrBits-1:0] nextPtr(input logic [ptrBits-1:0] ptr);
        return (ptr == ptrBits'(depth - 1)) ? '0 : ptr + 1'b1;
    endfunction

    assign full     = (count == countBits'(depth));
    assign empty    = (count == '0);
    assign doPush   = push && !full;
    assign doPop    = pop && !empty;
    assign headWord = words[rdPtr];
    assign headPc   = pcs[rdPtr];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else if (flush) begin
            rdPtr <= '0;
            wrPtr <= '0;
            count <= '0;
        end else begin
            if (doPush) wrPtr <= nextPtr(wrPtr);
            if (doPop)  rdPtr <= nextPtr(rdPtr);
            count <= count + countBits'(doPush) - countBits'(doPop);
        end
    end

    always_ff @(posedge CLK) begin
        if (doPush) begin
            words[wrPtr] <= pushWord;
            pcs[wrPtr]   <= pushPc;
        end
    end

endmodule

`default_nettype wire

// ==== design/regFile.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mipsCore_config.svh"

module regFile (
    input  logic            CLK,
    input  logic            arstN,
    input  mipsPkg::regIdxT readIdxA,
    input  mipsPkg::regIdxT readIdxB,
    output mipsPkg::wordT   readA,
    output mipsPkg::wordT   readB,
    input  logic            writeEn,
    input  mipsPkg::regIdxT writeIdx,
    input  mipsPkg::wordT   writeData
);
    import mipsPkg::*;

    wordT regs [`MIPS_NUM_REGS];

    // r0 is hardwired, a same-cycle write shows through
    assign readA = (readIdxA == '0) ? '0 :
                   (writeEn && writeIdx == readIdxA) ? writeData : regs[readIdxA];
    assign readB = (readIdxB == '0) ? '0 :
                   (writeEn && writeIdx == readIdxB) ? writeData : regs[readIdxB];

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (writeEn && writeIdx != '0) begin
            regs[writeIdx] <= writeData;
        end
    end

endmodule

`default_nettype wire

// ==== design/decodeUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mipsCore_config.svh"

module decodeUnit (
    input  logic            CLK,
    input  logic            arstN,
    input  logic            empty,
    input  mipsPkg::wordT   headWord,
    input  mipsPkg::addrT   headPc,
    output logic            pop,
    output logic            redirect,
    output mipsPkg::addrT   target,
    input  logic            regWriteEn,
    input  mipsPkg::regIdxT regWriteIdx,
    input  mipsPkg::wordT   regWriteData,
    issueBus.sender         issue
);
    import mipsPkg::*;

    logic [5:0] opcode;
    logic [5:0] funct;
    regIdxT     rs;
    regIdxT     rt;
    regIdxT     rd;
    wordT       immSext;
    wordT       immOp;
    wordT       shamtW;
    logic       isRType, isJ, isBeq, isBne, isLw, isSw, isImmAlu, isShift, isCtrl;
    logic       legalFunct;
    logic       legal;
    aluOpT      aluOp;
    regIdxT     srcA;
    regIdxT     destReg;
    logic       regWrite;
    logic       useA;
    logic       useB;
    wordT       valA;
    wordT       valB;
    wordT       opB;
    addrT       pcPlus4;
    logic       taken;
    logic       hazard;
    logic       outFree;
    logic       canGo;
    logic       doIssue;
    logic [`MIPS_NUM_REGS-1:0] regBusy;
    logic [`MIPS_NUM_REGS-1:0] busyNow;

    // ----------------------------------------------------------------------
    // Field split and instruction class
    // ----------------------------------------------------------------------
    assign opcode  = headWord[31:26];
    assign rs      = headWord[25:21];
    assign rt      = headWord[20:16];
    assign rd      = headWord[15:11];
    assign funct   = headWord[5:0];
    assign immSext = {{16{headWord[15]}}, headWord[15:0]};
    assign shamtW  = wordT'(headWord[10:6]);

    assign isRType  = (opcode == 6'h00);
    assign isJ      = (opcode == 6'h02);
    assign isBeq    = (opcode == 6'h04);
    assign isBne    = (opcode == 6'h05);
    assign isLw     = (opcode == 6'h23);
    assign isSw     = (opcode == 6'h2b);
    assign isImmAlu = (opcode == 6'h09) || (opcode[5:2] == 4'b0011 && opcode != 6'h0e);
    assign isShift  = isRType && (funct == 6'h00 || funct == 6'h02);
    assign isCtrl   = isJ || isBeq || isBne;
    assign legal    = (isRType && legalFunct) || isImmAlu || isLw || isSw || isCtrl;

    always_comb begin
        legalFunct = 1'b1;
        aluOp      = aluAdd;
        case (opcode)
            6'h00: begin
                case (funct)
                    6'h21:   aluOp = aluAdd;
                    6'h23:   aluOp = aluSub;
                    6'h24:   aluOp = aluAnd;
                    6'h25:   aluOp = aluOr;
                    6'h26:   aluOp = aluXor;
                    6'h2a:   aluOp = aluSlt;
                    6'h00:   aluOp = aluSll;
                    6'h02:   aluOp = aluSrl;
                    default: legalFunct = 1'b0;
                endcase
            end
            6'h0c:   aluOp = aluAnd;
            6'h0d:   aluOp = aluOr;
            6'h0f:   aluOp = aluLui;
            default: aluOp = aluAdd;
        endcase
    end

    // Shifts take their value from rt and the amount from the shamt field
    assign srcA     = isShift ? rt : rs;
    assign destReg  = isRType ? rd : rt;
    assign regWrite = ((isRType && legalFunct) || isImmAlu || isLw) && destReg != '0;
    assign useA     = !isJ;
    assign useB     = (isRType && !isShift) || isSw || isBeq || isBne;

    // andi, ori and lui zero-extend
    assign immOp = (opcode[5:2] == 4'b0011) ? wordT'(headWord[15:0]) : immSext;
    assign opB   = isShift ? shamtW : (isRType ? valB : immOp);

    regFile regs (
        .CLK       (CLK),
        .arstN     (arstN),
        .readIdxA  (srcA),
        .readIdxB  (rt),
        .readA     (valA),
        .readB     (valB),
        .writeEn   (regWriteEn),
        .writeIdx  (regWriteIdx),
        .writeData (regWriteData)
    );

    // ----------------------------------------------------------------------
    // Scoreboard and branch resolution
    // ----------------------------------------------------------------------
    // A register written back this cycle is already free through the
    // write-through read
    always_comb begin
        busyNow = regBusy;
        if (regWriteEn) busyNow[regWriteIdx] = 1'b0;
    end

    assign hazard = (useA && busyNow[srcA]) || (useB && busyNow[rt]) ||
                    (regWrite && busyNow[destReg]);

    assign pcPlus4 = headPc + addrT'(4);
    assign taken   = isJ || (isBeq && valA == valB) || (isBne && valA != valB);
    assign target  = isJ ? {pcPlus4[31:28], headWord[25:0], 2'b00}
                         : pcPlus4 + {immSext[29:0], 2'b00};

    assign outFree  = !issue.valid || issue.ready;
    assign canGo    = !empty && !hazard;
    assign redirect = canGo && taken;
    assign doIssue  = canGo && legal && !isCtrl && outFree;
    // Branches and unknown encodings leave without an issue slot
    assign pop      = canGo && (isCtrl || !legal || outFree);

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            regBusy <= '0;
        end else begin
            if (regWriteEn) regBusy[regWriteIdx] <= 1'b0;
            if (doIssue && regWrite) regBusy[destReg] <= 1'b1;
        end
    end

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            issue.valid <= 1'b0;
        end else if (outFree) begin
            issue.valid <= doIssue;
        end
    end

    always_ff @(posedge CLK) begin
        if (doIssue) begin
            issue.aluOp     <= aluOp;
            issue.destReg   <= destReg;
            issue.regWrite  <= regWrite;
            issue.memRead   <= isLw;
            issue.memWrite  <= isSw;
            issue.opA       <= valA;
            issue.opB       <= opB;
            issue.storeData <= valB;
        end
    end

endmodule

`default_nettype wire

// ==== design/executeUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module executeUnit (
    input  logic     CLK,
    input  logic     arstN,
    issueBus.receiver issue,
    memBus.sender    toMem
);
    import mipsPkg::*;

    wordT aluResult;

    // Loads and stores use the sum as their address
    always_comb begin
        case (issue.aluOp)
            aluAdd:  aluResult = issue.opA + issue.opB;
            aluSub:  aluResult = issue.opA - issue.opB;
            aluAnd:  aluResult = issue.opA & issue.opB;
            aluOr:   aluResult = issue.opA | issue.opB;
            aluXor:  aluResult = issue.opA ^ issue.opB;
            aluSlt:  aluResult = wordT'($signed(issue.opA) < $signed(issue.opB));
            aluSll:  aluResult = issue.opA << issue.opB[4:0];
            aluSrl:  aluResult = issue.opA >> issue.opB[4:0];
            aluLui:  aluResult = {issue.opB[15:0], 16'h0000};
            default: aluResult = '0;
        endcase
    end

    // Output stage takes a new item when empty or draining
    assign issue.ready = !toMem.valid || toMem.ready;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            toMem.valid <= 1'b0;
        end else if (issue.ready) begin
            toMem.valid <= issue.valid;
        end
    end

    always_ff @(posedge CLK) begin
        if (issue.valid && issue.ready) begin
            toMem.result    <= aluResult;
            toMem.destReg   <= issue.destReg;
            toMem.regWrite  <= issue.regWrite;
            toMem.memRead   <= issue.memRead;
            toMem.memWrite  <= issue.memWrite;
            toMem.storeData <= issue.storeData;
        end
    end

endmodule

`default_nettype wire

// ==== design/memoryUnit.sv ====
`timescale 1ns/1ns
`default_nettype none

module memoryUnit (
    input  logic            CLK,
    input  logic            arstN,
    memBus.receiver         fromExec,
    output logic            regWriteEn,
    output mipsPkg::regIdxT regWriteIdx,
    output mipsPkg::wordT   regWriteData,
    output logic            wbCyc,
    output logic            wbStb,
    output logic            wbWe,
    output mipsPkg::addrT   wbAdr,
    output mipsPkg::wordT   wbDatW,
    input  mipsPkg::wordT   wbDatR,
    input  logic            wbAck
);
    import mipsPkg::*;

    memStateT state;
    wordT     resultReg;
    wordT     storeReg;
    regIdxT   destReg;
    logic     regWrite;
    logic     memRead;
    logic     memWrite;

    assign fromExec.ready = (state == idle);

    // Classic cycle, strobe held until ack
    assign wbCyc  = (state == busy);
    assign wbStb  = (state == busy);
    assign wbWe   = (state == busy) && memWrite;
    assign wbAdr  = resultReg;
    assign wbDatW = storeReg;

    // resultReg holds the ALU value, or the load data once ack arrives
    assign regWriteEn   = (state == writeback) && regWrite;
    assign regWriteIdx  = destReg;
    assign regWriteData = resultReg;

    always_ff @(posedge CLK or negedge arstN) begin
        if (!arstN) begin
            state <= idle;
        end else begin
            case (state)
                idle: begin
                    if (fromExec.valid) begin
                        state <= (fromExec.memRead || fromExec.memWrite) ? busy : writeback;
                    end
                end
                busy: begin
                    if (wbAck) state <= writeback;
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge CLK) begin
        if (fromExec.valid && fromExec.ready) begin
            resultReg <= fromExec.result;
            storeReg  <= fromExec.storeData;
            destReg   <= fromExec.destReg;
            regWrite  <= fromExec.regWrite;
            memRead   <= fromExec.memRead;
            memWrite  <= fromExec.memWrite;
        end else if (state == busy && wbAck && memRead) begin
            resultReg <= wbDatR;
        end
    end

endmodule

`default_nettype wire

// ==== design/mipsCore.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mipsCore_config.svh"

module mipsCore (
    input  logic          CLK,
    input  logic          arstN,
    output mipsPkg::addrT instrAddr,
    input  mipsPkg::wordT instrData,
    output logic          wbCyc,
    output logic          wbStb,
    output logic          wbWe,
    output mipsPkg::addrT wbAdr,
    output mipsPkg::wordT wbDatW,
    input  mipsPkg::wordT wbDatR,
    input  logic          wbAck
);
    import mipsPkg::*;

    logic   redirect;
    addrT   target;
    logic   queueFull;
    logic   queueEmpty;
    logic   push;
    logic   pop;
    wordT   pushWord;
    wordT   headWord;
    addrT   pushPc;
    addrT   headPc;
    logic   regWriteEn;
    regIdxT regWriteIdx;
    wordT   regWriteData;

    issueBus issueIf ();
    memBus   memIf ();

    // ----------------------------------------------------------------------
    // Front end
    // ----------------------------------------------------------------------
    fetchUnit fetch (
        .CLK       (CLK),
        .arstN     (arstN),
        .redirect  (redirect),
        .target    (target),
        .queueFull (queueFull),
        .instrData (instrData),
        .instrAddr (instrAddr),
        .push      (push),
        .pushWord  (pushWord),
        .pushPc    (pushPc)
    );

    // Taken branches and jumps drop everything fetched behind them
    instrQueue #(
        .depth (`MIPS_QUEUE_DEPTH)
    ) queue (
        .CLK      (CLK),
        .arstN    (arstN),
        .flush    (redirect),
        .push     (push),
        .pop      (pop),
        .pushWord (pushWord),
        .pushPc   (pushPc),
        .full     (queueFull),
        .empty    (queueEmpty),
        .headWord (headWord),
        .headPc   (headPc)
    );

    decodeUnit decode (
        .CLK          (CLK),
        .arstN        (arstN),
        .empty        (queueEmpty),
        .headWord     (headWord),
        .headPc       (headPc),
        .pop          (pop),
        .redirect     (redirect),
        .target       (target),
        .regWriteEn   (regWriteEn),
        .regWriteIdx  (regWriteIdx),
        .regWriteData (regWriteData),
        .issue        (issueIf.sender)
    );

    // ----------------------------------------------------------------------
    // Back end
    // ----------------------------------------------------------------------
    executeUnit execute (
        .CLK   (CLK),
        .arstN (arstN),
        .issue (issueIf.receiver),
        .toMem (memIf.sender)
    );

    memoryUnit memory (
        .CLK          (CLK),
        .arstN        (arstN),
        .fromExec     (memIf.receiver),
        .regWriteEn   (regWriteEn),
        .regWriteIdx  (regWriteIdx),
        .regWriteData (regWriteData),
        .wbCyc        (wbCyc),
        .wbStb        (wbStb),
        .wbWe         (wbWe),
        .wbAdr        (wbAdr),
        .wbDatW       (wbDatW),
        .wbDatR       (wbDatR),
        .wbAck        (wbAck)
    );

endmodule

`default_nettype wire

// ==== test/mipsCoreTb.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "mipsCore_config.svh"

module mipsCoreTb;
    import mipsPkg::*;

    localparam int numStores    = 16;
    localparam int waitLimit    = 1000;
    localparam int quietCycles  = 200;

    logic CLK;
    logic arstN;
    addrT instrAddr;
    wordT instrData;
    logic wbCyc;
    logic wbStb;
    logic wbWe;
    addrT wbAdr;
    wordT wbDatW;
    wordT wbDatR;
    logic wbAck;

    wordT        rom [64];
    wordT        progWords [42];
    wordT        dataMem [128];
    logic        inXfer;
    logic [1:0]  waitLeft;
    logic [31:0] rngState;
    logic [31:0] rngNext;
    addrT        writeAddrs [$];
    wordT        writeDatas [$];

    // Hand-computed stores in program order
    addrT expAddr [numStores] = '{
        32'h100, 32'h104, 32'h108, 32'h10c, 32'h110, 32'h114, 32'h118, 32'h11c,
        32'h120, 32'h124, 32'h128, 32'h12c, 32'h184, 32'h130, 32'h134, 32'h138
    };
    wordT expData [numStores] = '{
        32'h0000_0002, 32'h0000_0008, 32'h0000_0005, 32'hffff_fffd,
        32'hffff_fff8, 32'h0000_0001, 32'h0000_0050, 32'h0000_000f,
        32'h1234_abcd, 32'h0000_ff0d, 32'h2469_579c, 32'hcafe_f00d,
        32'h1234_abcd, 32'h1234_abce, 32'h0000_0005, 32'h0000_0001
    };

    mipsCore uut (
        .CLK       (CLK),
        .arstN     (arstN),
        .instrAddr (instrAddr),
        .instrData (instrData),
        .wbCyc     (wbCyc),
        .wbStb     (wbStb),
        .wbWe      (wbWe),
        .wbAdr     (wbAdr),
        .wbDatW    (wbDatW),
        .wbDatR    (wbDatR),
        .wbAck     (wbAck)
    );

    always #5 CLK = ~CLK;

    // ----------------------------------------------------------------------
    // Instruction encoders and helpers
    // ----------------------------------------------------------------------
    function automatic wordT rFormat(input regIdxT rs, input regIdxT rt, input regIdxT rd,
                                     input logic [4:0] shamt, input logic [5:0] funct);
        return {6'h00, rs, rt, rd, shamt, funct};
    endfunction

    function automatic wordT iFormat(input logic [5:0] op, input regIdxT rs, input regIdxT rt,
                                     input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    function automatic wordT jFormat(input logic [25:0] index);
        return {6'h02, index};
    endfunction

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic failRun(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkAddr(input string name, input addrT got, input addrT exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            failRun($sformatf("ERROR: %s = 0x%h, expected 0x%h", name, got, exp));
        end
    endtask

    // ----------------------------------------------------------------------
    // Memory models
    // ----------------------------------------------------------------------
    assign instrData = rom[instrAddr[7:2]];
    assign rngNext   = xorshift(rngState);

    // Wishbone classic slave with 0 to 3 wait cycles per transfer
    always @(posedge CLK) begin
        if (!arstN) begin
            wbAck  <= 1'b0;
            inXfer <= 1'b0;
        end else if (wbAck) begin
            wbAck  <= 1'b0;
            inXfer <= 1'b0;
        end else if (wbCyc && wbStb) begin
            if (!inXfer) begin
                inXfer   <= 1'b1;
                rngState <= rngNext;
                waitLeft <= rngNext[1:0];
            end else if (waitLeft != 2'd0) begin
                waitLeft <= waitLeft - 2'd1;
            end else begin
                wbAck <= 1'b1;
                if (wbWe) begin
                    dataMem[wbAdr[8:2]] <= wbDatW;
                    writeAddrs.push_back(wbAdr);
                    writeDatas.push_back(wbDatW);
                end else begin
                    wbDatR <= dataMem[wbAdr[8:2]];
                end
            end
        end
    end

    // Strobe rises with cycle, and both hold until ack is seen
    always @(negedge CLK) begin
        if (arstN) begin
            checkFlag("wbStb", wbStb, wbCyc);
            if (inXfer) begin
                checkFlag("wbCyc", wbCyc, 1'b1);
            end
        end
    end

    // ----------------------------------------------------------------------
    // Program
    // ----------------------------------------------------------------------
    task automatic loadProgram();
        progWords[0]  = iFormat(6'h09, 5'd0, 5'd1, 16'd5);
        progWords[1]  = iFormat(6'h09, 5'd0, 5'd2, 16'hfffd);
        progWords[2]  = rFormat(5'd1, 5'd2, 5'd3, 5'd0, 6'h21);
        progWords[3]  = iFormat(6'h2b, 5'd0, 5'd3, 16'h0100);
        progWords[4]  = rFormat(5'd1, 5'd2, 5'd4, 5'd0, 6'h23);
        progWords[5]  = iFormat(6'h2b, 5'd0, 5'd4, 16'h0104);
        progWords[6]  = rFormat(5'd1, 5'd2, 5'd5, 5'd0, 6'h24);
        progWords[7]  = iFormat(6'h2b, 5'd0, 5'd5, 16'h0108);
        progWords[8]  = rFormat(5'd1, 5'd2, 5'd6, 5'd0, 6'h25);
        progWords[9]  = iFormat(6'h2b, 5'd0, 5'd6, 16'h010c);
        progWords[10] = rFormat(5'd1, 5'd2, 5'd7, 5'd0, 6'h26);
        progWords[11] = iFormat(6'h2b, 5'd0, 5'd7, 16'h0110);
        progWords[12] = rFormat(5'd2, 5'd1, 5'd8, 5'd0, 6'h2a);
        progWords[13] = iFormat(6'h2b, 5'd0, 5'd8, 16'h0114);
        progWords[14] = rFormat(5'd0, 5'd1, 5'd9, 5'd4, 6'h00);
        progWords[15] = iFormat(6'h2b, 5'd0, 5'd9, 16'h0118);
        progWords[16] = rFormat(5'd0, 5'd2, 5'd10, 5'd28, 6'h02);
        progWords[17] = iFormat(6'h2b, 5'd0, 5'd10, 16'h011c);
        // lui then ori on the same register back to back
        progWords[18] = iFormat(6'h0f, 5'd0, 5'd11, 16'h1234);
        progWords[19] = iFormat(6'h0d, 5'd11, 5'd11, 16'habcd);
        progWords[20] = iFormat(6'h2b, 5'd0, 5'd11, 16'h0120);
        progWords[21] = iFormat(6'h0c, 5'd2, 5'd12, 16'hff0f);
        progWords[22] = iFormat(6'h2b, 5'd0, 5'd12, 16'h0124);
        progWords[23] = iFormat(6'h09, 5'd11, 5'd13, 16'd1);
        progWords[24] = rFormat(5'd13, 5'd13, 5'd13, 5'd0, 6'h21);
        progWords[25] = iFormat(6'h2b, 5'd0, 5'd13, 16'h0128);
        progWords[26] = iFormat(6'h23, 5'd0, 5'd14, 16'h0180);
        progWords[27] = iFormat(6'h2b, 5'd0, 5'd14, 16'h012c);
        // Store, then load the same word back
        progWords[28] = iFormat(6'h2b, 5'd0, 5'd11, 16'h0184);
        progWords[29] = iFormat(6'h23, 5'd0, 5'd15, 16'h0184);
        progWords[30] = iFormat(6'h09, 5'd15, 5'd15, 16'd1);
        progWords[31] = iFormat(6'h2b, 5'd0, 5'd15, 16'h0130);
        // Taken beq skips the two stores after it
        progWords[32] = iFormat(6'h04, 5'd1, 5'd1, 16'd2);
        progWords[33] = iFormat(6'h2b, 5'd0, 5'd1, 16'h01f0);
        progWords[34] = iFormat(6'h2b, 5'd0, 5'd2, 16'h01f4);
        progWords[35] = iFormat(6'h05, 5'd1, 5'd1, 16'd1);
        progWords[36] = iFormat(6'h2b, 5'd0, 5'd1, 16'h0134);
        progWords[37] = jFormat(26'h28);
        progWords[38] = iFormat(6'h2b, 5'd0, 5'd1, 16'h01f8);
        progWords[39] = iFormat(6'h2b, 5'd0, 5'd1, 16'h01fc);
        progWords[40] = iFormat(6'h2b, 5'd0, 5'd8, 16'h0138);
        progWords[41] = jFormat(26'h29);
    endtask

    initial begin
        int   waited;
        addrT gotAddr;
        wordT gotData;

        CLK      = 1'b0;
        arstN    = 1'b0;
        wbAck    = 1'b0;
        wbDatR   = '0;
        inXfer   = 1'b0;
        waitLeft = 2'd0;
        rngState = 32'hb1e1117a;
        loadProgram();
        for (int i = 0; i < 64; i++) begin
            rom[i] = (i < 42) ? progWords[i] : '0;
        end
        for (int i = 0; i < 128; i++) begin
            dataMem[i] = '0;
        end
        dataMem[7'h60] = 32'hcafe_f00d;

        repeat (2) @(posedge CLK);
        @(negedge CLK);
        checkAddr("instrAddr", instrAddr, `MIPS_RESET_PC);
        checkFlag("wbCyc", wbCyc, 1'b0);
        @(posedge CLK);
        arstN <= 1'b1;

        // First bus cycle must be the first store in the program
        waited = 0;
        while (!wbCyc && waited < waitLimit) begin
            @(negedge CLK);
            waited++;
        end
        if (!wbCyc) begin
            failRun("No Wishbone cycle started after reset");
        end
        checkAddr("wbAdr", wbAdr, expAddr[0]);
        checkFlag("wbWe", wbWe, 1'b1);

        for (int i = 0; i < numStores; i++) begin
            waited = 0;
            while (writeAddrs.size() == 0 && waited < waitLimit) begin
                @(negedge CLK);
                waited++;
            end
            if (writeAddrs.size() == 0) begin
                failRun($sformatf("Store number %0d never arrived", i));
            end
            gotAddr = writeAddrs.pop_front();
            gotData = writeDatas.pop_front();
            checkAddr("wbAdr", gotAddr, expAddr[i]);
            checkWord("wbDatW", gotData, expData[i]);
        end

        repeat (quietCycles) @(negedge CLK);
        if (writeAddrs.size() != 0) begin
            failRun("A store appeared after the last expected one");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+design
design/mipsPkg.sv
design/stageBuses.sv
design/fetchUnit.sv
design/instrQueue.sv
design/regFile.sv
design/decodeUnit.sv
design/executeUnit.sv
design/memoryUnit.sv
design/mipsCore.sv
test/mipsCoreTb.sv
